// File: Makefile
# Verilator build and run for the sample transform engine

SIM  := obj_dir/Vtb_xform
SRCS := $(wildcard hdl/*.sv hdl/*.svh test/*.sv)

.PHONY: all run clean

all: run

$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module tb_xform -o Vtb_xform

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
+incdir+hdl
hdl/xform_pkg.sv
hdl/pattern_gen.sv
hdl/mix_unit.sv
hdl/sample_buffer.sv
hdl/xform_ctrl.sv
hdl/xform_top.sv
test/tb_xform.sv

// File: hdl/mix_unit.sv
// ####################################################################
// Combinational mix word generator, one of four byte functions by mode
// ####################################################################

`timescale 1ns/10ps
`default_nettype none

module mix_unit
    import xform_pkg::*;
(
    input  mix_operands_u operands,
    input  xform_mode_e   mode,
    output mix_word_t     mix_word
);

    mix_bytes_t op;
    logic [7:0] b_plus_c;
    logic [7:0] a_plus_b;
    mix_word_t  prod;
    mix_word_t  diff;

    // Decode the byte view of the pattern slice
    assign op = operands.bytes;

    // Byte sums wrap at 8 bits
    assign b_plus_c = op.b + op.c;
    assign a_plus_b = op.a + op.b;

    assign prod = {8'h00, op.a} * {8'h00, op.b};   // Fits in 16 bits
    assign diff = {op.d, op.e} - {op.a, op.c};     // Wraps modulo 2^16

    always_comb begin
        case (mode)
            MIX_SPLIT: begin
                mix_word = {op.a ^ op.e, b_plus_c};
            end
            MIX_SUM: begin
                mix_word = {a_plus_b, op.c ^ op.d};
            end
            MIX_PROD: begin
                mix_word = prod ^ {8'h00, op.e};
            end
            MIX_DIFF: begin
                mix_word = diff;
            end
            default: begin
                mix_word = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/pattern_gen.sv
// ####################################################################
// Free-running 160-bit feedback shift register for the mix operands
// ####################################################################

`timescale 1ns/10ps
`default_nettype none

`include "xform_config.svh"

module pattern_gen
    import xform_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    step,
    output mix_operands_u operands
);

    logic [159:0] pattern;
    logic         feedback;

    // Taps at 159, 127 and 95
    assign feedback = pattern[159] ^ pattern[127] ^ pattern[95];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pattern <= `XFORM_SEED;
        end else if (step) begin
            pattern <= {pattern[158:0], feedback};   // Shift left by one
        end
    end

    // Only bits 47..8 reach the mix unit
    assign operands.raw = pattern[47:8];

endmodule

`default_nettype wire

// File: hdl/sample_buffer.sv
// ####################################################################
// Result frame storage with per-index load and XOR update
// ####################################################################

`timescale 1ns/10ps
`default_nettype none

module sample_buffer
    import xform_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             load_en,
    input  wire logic             mix_en,
    input  wire logic [IDX_W-1:0] index,
    input  frame_t                frame_in,
    input  mix_word_t             mix_word,
    output frame_t                frame_out
);

    frame_t  frame_q;
    sample_t cur;
    sample_t mixed;

    // Entry addressed this cycle
    assign cur = frame_q[index];

    // Same word goes into both halves
    assign mixed.re = cur.re ^ mix_word;
    assign mixed.im = cur.im ^ mix_word;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_q <= '0;
        end else if (load_en) begin
            frame_q[index] <= frame_in[index];   // Copy phase
        end else if (mix_en) begin
            frame_q[index] <= mixed;             // One pass step
        end
    end

    assign frame_out = frame_q;

    // Controller phases never overlap
    a_one_op: assert property (
        @(posedge clk) disable iff (rst)
        !(load_en && mix_en)
    );

endmodule

`default_nettype wire

// File: hdl/xform_config.svh
// ####################################################################
// Build-time sizing and seed for the sample transform engine
// ####################################################################

`ifndef XFORM_CONFIG_SVH
`define XFORM_CONFIG_SVH

// Samples per frame, a power of two of at least 4
`define XFORM_SIZE 8

// Width of one real or imaginary component
`define XFORM_WIDTH 16

// Reset value of the pattern register
// Must be nonzero or the feedback register locks up
`define XFORM_SEED 160'h1234_5678_9ABC_DEF0_1234_5678_9ABC_DEF0_1234_5678

`endif

// File: hdl/xform_ctrl.sv
// ####################################################################
// Sequencer for frame load, mixing passes and the done pulse
// ####################################################################

`timescale 1ns/10ps
`default_nettype none

module xform_ctrl
    import xform_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start,
    output logic                   busy,
    output logic                   done,
    output logic                   step,
    output logic                   load_en,
    output logic                   mix_en,
    output logic [IDX_W-1:0]       index
);

    typedef enum logic [1:0] {
        S_IDLE     = 2'd0,
        S_LOAD     = 2'd1,
        S_COMPUTE  = 2'd2,
        S_COMPLETE = 2'd3
    } state_e;

    state_e            state;
    logic [IDX_W-1:0]  index_q;
    logic [PASS_W-1:0] pass_q;
    logic              done_pend;   // Set on the complete edge
    logic              last_idx;
    logic              last_pass;

    assign last_idx  = (index_q == IDX_W'(N_SAMPLES - 1));
    assign last_pass = (pass_q == PASS_W'(NUM_PASSES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            index_q   <= '0;
            pass_q    <= '0;
            done_pend <= 1'b0;
            done      <= 1'b0;
        end else begin
            done_pend <= (state == S_COMPLETE);
            done      <= done_pend;

            case (state)
                S_IDLE: begin
                    if (start) begin
                        index_q <= '0;
                        pass_q  <= '0;
                        state   <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    if (last_idx) begin
                        index_q <= '0;
                        state   <= S_COMPUTE;
                    end else begin
                        index_q <= index_q + 1'b1;
                    end
                end
                S_COMPUTE: begin
                    if (last_idx) begin
                        index_q <= '0;
                        if (last_pass) begin
                            state <= S_COMPLETE;   // Last sample of last pass
                        end else begin
                            pass_q <= pass_q + 1'b1;
                        end
                    end else begin
                        index_q <= index_q + 1'b1;
                    end
                end
                S_COMPLETE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign busy    = (state != S_IDLE);
    assign step    = busy || start;   // Start cycle plus every busy cycle
    assign load_en = (state == S_LOAD);
    assign mix_en  = (state == S_COMPUTE);
    assign index   = index_q;

    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    );

    a_index_range: assert property (
        @(posedge clk) disable iff (rst)
        busy |-> (index_q < N_SAMPLES)
    );

endmodule

`default_nettype wire

// File: hdl/xform_pkg.sv
// ####################################################################
// Shared types for the sample transform engine
// ####################################################################

`default_nettype none

`include "xform_config.svh"

package xform_pkg;

    localparam int N_SAMPLES  = `XFORM_SIZE;
    localparam int NUM_PASSES = $clog2(`XFORM_SIZE);   // log2(N) passes
    localparam int IDX_W      = $clog2(`XFORM_SIZE);
    localparam int PASS_W     = $clog2(NUM_PASSES);
    localparam int MIX_W      = 16;

    typedef logic [MIX_W-1:0] mix_word_t;

    // One complex sample
    typedef struct packed {
        logic [`XFORM_WIDTH-1:0] re;
        logic [`XFORM_WIDTH-1:0] im;
    } sample_t;

    typedef sample_t [N_SAMPLES-1:0] frame_t;

    // Selects the mixing function
    typedef enum logic [1:0] {
        MIX_SPLIT = 2'd0,
        MIX_SUM   = 2'd1,
        MIX_PROD  = 2'd2,
        MIX_DIFF  = 2'd3
    } xform_mode_e;

    // Byte view, a is the top byte
    typedef struct packed {
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] c;
        logic [7:0] d;
        logic [7:0] e;
    } mix_bytes_t;

    // Raw pattern slice or the five operand bytes
    typedef union packed {
        logic [39:0] raw;
        mix_bytes_t  bytes;
    } mix_operands_u;

endpackage

`default_nettype wire

// File: hdl/xform_top.sv
// ####################################################################
// Sample transform engine top, controller plus mixing datapath
// ####################################################################

`timescale 1ns/10ps
`default_nettype none

module xform_top
    import xform_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  start,
    input  xform_mode_e mode,
    input  frame_t      frame_in,
    output frame_t      frame_out,
    output logic        busy,
    output logic        done
);

    logic             step;
    logic             load_en;
    logic             mix_en;
    logic [IDX_W-1:0] index;
    mix_operands_u    operands;
    mix_word_t        mix_word;

    xform_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .step    (step),
        .load_en (load_en),
        .mix_en  (mix_en),
        .index   (index)
    );

    // Runs across frames, never cleared between them
    pattern_gen u_pattern (
        .clk      (clk),
        .rst      (rst),
        .step     (step),
        .operands (operands)
    );

    mix_unit u_mix (
        .operands (operands),
        .mode     (mode),
        .mix_word (mix_word)
    );

    sample_buffer u_buffer (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .mix_en    (mix_en),
        .index     (index),
        .frame_in  (frame_in),
        .mix_word  (mix_word),
        .frame_out (frame_out)
    );

endmodule

`default_nettype wire

// File: test/tb_xform.sv
// ####################################################################
// Testbench for the sample transform engine with a reference model
// ####################################################################

`timescale 1ns/10ps
`default_nettype none

`include "xform_config.svh"

module tb_xform import xform_pkg::*; ();

    localparam int DONE_EDGE  = N_SAMPLES + N_SAMPLES * NUM_PASSES + 2;
    localparam int BUSY_LAST  = DONE_EDGE - 2;   // Last edge still followed by busy
    localparam int WAIT_LIMIT = DONE_EDGE + 20;
    localparam int FRAME_BITS = $bits(frame_t);

    logic        clk;
    logic        rst;
    logic        start;
    xform_mode_e mode;
    frame_t      frame_in;
    frame_t      frame_out;
    logic        busy;
    logic        done;

    logic [159:0] ref_pattern;      // Model copy of the pattern register
    frame_t       expected_q[$];
    int           frames_sent;
    int           frames_checked;

    xform_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .mode      (mode),
        .frame_in  (frame_in),
        .frame_out (frame_out),
        .busy      (busy),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_equal(input logic [FRAME_BITS-1:0] got,
                               input logic [FRAME_BITS-1:0] want, input string what);
        if (got !== want) begin
            $display("ERROR at %0t: %s, got %0h expected %0h", $time, what, got, want);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [159:0] pattern_next(input logic [159:0] p);
        return {p[158:0], p[159] ^ p[127] ^ p[95]};
    endfunction

    // Mix word from operand bytes at pattern bits 47..8
    function automatic logic [15:0] mix_value(input logic [159:0] p, input xform_mode_e m);
        logic [7:0]  a, b, c, d, e;
        logic [15:0] r;
        a = p[47:40];
        b = p[39:32];
        c = p[31:24];
        d = p[23:16];
        e = p[15:8];
        case (m)
            MIX_SPLIT: r = {a ^ e, 8'(b + c)};
            MIX_SUM:   r = {8'(a + b), c ^ d};
            MIX_PROD:  r = (16'(a) * 16'(b)) ^ {8'h00, e};
            default:   r = {d, e} - {a, c};
        endcase
        return r;
    endfunction

    // Expected frame, advances the model pattern over one whole transform
    function automatic frame_t expected_frame(input frame_t in, input xform_mode_e m);
        frame_t      f;
        logic [15:0] w;
        f = in;                                     // Load copies every sample
        ref_pattern = pattern_next(ref_pattern);    // Start edge
        for (int k = 0; k < N_SAMPLES; k++) begin
            ref_pattern = pattern_next(ref_pattern);
        end
        for (int p = 0; p < NUM_PASSES; p++) begin
            for (int i = 0; i < N_SAMPLES; i++) begin
                w = mix_value(ref_pattern, m);
                f[i].re = f[i].re ^ w;
                f[i].im = f[i].im ^ w;
                ref_pattern = pattern_next(ref_pattern);
            end
        end
        ref_pattern = pattern_next(ref_pattern);    // Complete edge
        return f;
    endfunction

    function automatic frame_t random_frame();
        frame_t      f;
        logic [31:0] r;
        for (int k = 0; k < N_SAMPLES; k++) begin
            r = $urandom;
            f[k].re = r[`XFORM_WIDTH-1:0];
            r = $urandom;
            f[k].im = r[`XFORM_WIDTH-1:0];
        end
        return f;
    endfunction

    // Compares the result on the cycle done is high
    always @(posedge clk) begin
        if (!rst && done) begin
            if (expected_q.size() == 0) begin
                abort_run("done pulsed with no transform outstanding");
            end else begin
                check_equal(frame_out, expected_q.pop_front(), "frame_out after done");
                frames_checked = frames_checked + 1;
            end
        end
    end

    // One transform, optionally with start pulses while busy
    task automatic run_frame(input xform_mode_e m, input frame_t f, input logic extra_start);
        int edges;
        @(posedge clk);
        mode     <= m;
        frame_in <= f;
        start    <= 1'b1;
        expected_q.push_back(expected_frame(f, m));
        frames_sent = frames_sent + 1;
        @(posedge clk);                 // Edge 0 samples start
        start <= 1'b0;
        edges = 0;
        while (1) begin
            @(negedge clk);
            if (done) begin
                break;
            end
            check_equal(busy, (edges <= BUSY_LAST), "busy during transform");
            if (edges >= WAIT_LIMIT) begin
                abort_run("timeout, done never arrived after start");
            end
            @(posedge clk);
            edges = edges + 1;
            start <= extra_start && (edges == 3 || edges == BUSY_LAST);
        end
        check_equal(edges, DONE_EDGE, "edges from start to done");
        check_equal(busy, 1'b0, "busy while done is high");
        @(negedge clk);
        check_equal(done, 1'b0, "done longer than one cycle");
    endtask

    initial begin
        void'($urandom(2133));
        rst            = 1'b1;
        start          = 1'b0;
        mode           = MIX_SPLIT;
        frame_in       = '0;
        ref_pattern    = `XFORM_SEED;
        frames_sent    = 0;
        frames_checked = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_equal(done, 1'b0, "done after reset");
        check_equal(busy, 1'b0, "busy after reset");
        check_equal(frame_out, '0, "frame_out after reset");

        // Each mode once
        for (int i = 0; i < 4; i++) begin
            run_frame(xform_mode_e'(i), random_frame(), 1'b0);
        end
        // Back to back frames, pattern keeps running
        for (int i = 0; i < 6; i++) begin
            run_frame(xform_mode_e'($urandom_range(3, 0)), random_frame(), 1'b0);
        end
        run_frame(MIX_PROD, random_frame(), 1'b1);
        run_frame(MIX_DIFF, random_frame(), 1'b1);
        run_frame(MIX_SPLIT, random_frame(), 1'b0);

        if (frames_checked == frames_sent && expected_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run("checker saw fewer results than transforms started");
        end
    end

endmodule

`default_nettype wire
